// File: source/z80_settings.svh
`ifndef Z80_SETTINGS_SVH
`define Z80_SETTINGS_SVH

`define Z80_ADDR_W    16
`define Z80_DATA_W    8
`define Z80_RESET_PC  16'h0000

// pair-addressed accumulator loads
`define OP_LD_A_BC    8'h0A
`define OP_LD_A_DE    8'h1A
`define OP_LD_BC_A    8'h02
`define OP_LD_DE_A    8'h12

// extended addressing and (HL) immediate
`define OP_LD_A_NN    8'h3A
`define OP_LD_NN_A    8'h32
`define OP_LD_HL_N    8'h36

// opcode[7:6] for the field-coded forms
`define OP_MASK_LD_RR 2'b01    // 01 ddd sss
`define OP_MASK_LD_RN 2'b00    // 00 ddd 110

`endif

// File: source/z80_pkg.sv
`include "z80_settings.svh"

package z80_pkg;

    typedef logic [`Z80_ADDR_W-1:0] addr_t;
    typedef logic [`Z80_DATA_W-1:0] data_t;

    // 3-bit register field of an opcode
    typedef enum logic [2:0] {
        B      = 3'd0,
        C      = 3'd1,
        D      = 3'd2,
        E      = 3'd3,
        H      = 3'd4,
        L      = 3'd5,
        MEM_HL = 3'd6,    // memory at (HL) rather than a register
        A      = 3'd7
    } reg_code_t;

    typedef enum logic [1:0] {BC, DE, HL} pair_sel_t;

    typedef enum logic [3:0] {
        LD_REG_REG,
        LD_REG_IMMED,
        LD_A_BCDE,
        LD_BCDE_A,
        LD_HL_REG,
        LD_HL_IMMED,
        LD_A_EXTADDR,
        LD_EXTADDR_A,
        NOP_OTHER
    } insn_group_t;

    typedef enum logic [1:0] {S0, S1, S2, S3} seq_state_t;

    typedef struct packed {
        addr_t addr;
        logic  rd;
        logic  wr;
        data_t wdata;
    } mem_req_t;

endpackage

// File: source/register_file.sv
`timescale 1ns/1ns

module register_file import z80_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      wr_en_i,
    input  reg_code_t wr_code_i,
    input  data_t     wr_data_i,
    input  reg_code_t rd_code_i,
    output data_t     rd_data_o,
    input  pair_sel_t pair_sel_i,
    output addr_t     pair_data_o
);

    data_t regs [7];    // b c d e h l a

    // a sits in the slot that MEM_HL leaves free
    function automatic logic [2:0] slot(input reg_code_t code);
        return (code == A) ? 3'd6 : 3'(code);
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 7; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && wr_code_i != MEM_HL) begin
            regs[slot(wr_code_i)] <= wr_data_i;
        end
    end

    always_comb begin
        if (rd_code_i == MEM_HL) begin
            rd_data_o = '0;
        end else begin
            rd_data_o = regs[slot(rd_code_i)];
        end
    end

    always_comb begin
        case (pair_sel_i)
            BC:      pair_data_o = {regs[0], regs[1]};
            DE:      pair_data_o = {regs[2], regs[3]};
            default: pair_data_o = {regs[4], regs[5]};    // hl
        endcase
    end

endmodule

// File: source/instr_decoder.sv
`timescale 1ns/1ns
`include "z80_settings.svh"

module instr_decoder import z80_pkg::*; (
    input  data_t       opcode_i,
    output insn_group_t group_o
);

    reg_code_t dst_code;
    reg_code_t src_code;

    assign dst_code = reg_code_t'(opcode_i[5:3]);
    assign src_code = reg_code_t'(opcode_i[2:0]);

    always_comb begin
        group_o = NOP_OTHER;
        case (opcode_i)
            `OP_LD_A_BC, `OP_LD_A_DE: group_o = LD_A_BCDE;
            `OP_LD_BC_A, `OP_LD_DE_A: group_o = LD_BCDE_A;
            `OP_LD_A_NN:              group_o = LD_A_EXTADDR;
            `OP_LD_NN_A:              group_o = LD_EXTADDR_A;
            `OP_LD_HL_N:              group_o = LD_HL_IMMED;
            default: begin
                if (opcode_i[7:6] == `OP_MASK_LD_RR) begin
                    // halt (both fields 6) and LD r,(HL) stay no-ops
                    if (src_code != MEM_HL) begin
                        if (dst_code == MEM_HL) begin
                            group_o = LD_HL_REG;
                        end else begin
                            group_o = LD_REG_REG;
                        end
                    end
                end else if (opcode_i[7:6] == `OP_MASK_LD_RN && src_code == MEM_HL) begin
                    // low field 110 marks the immediate form
                    group_o = LD_REG_IMMED;
                end
            end
        endcase
    end

endmodule

// File: source/load_sequencer.sv
`timescale 1ns/1ns
`include "z80_settings.svh"

module load_sequencer import z80_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  data_t       mem_data_i,
    output mem_req_t    mem_req_o,
    output logic        done_o,
    input  insn_group_t group_i,
    output data_t       opcode_o,
    output logic        reg_wr_en_o,
    output reg_code_t   reg_wr_code_o,
    output data_t       reg_wr_data_o,
    output reg_code_t   reg_rd_code_o,
    input  data_t       reg_rd_data_i,
    output pair_sel_t   pair_sel_o,
    input  addr_t       pair_data_i
);

    seq_state_t state;
    seq_state_t next_state;
    data_t      opcode_q;
    data_t      nn_lo;        // low byte of nn
    data_t      next_nn_lo;
    addr_t      ret_addr;     // pc after the instruction
    addr_t      next_ret;
    addr_t      pc_inc;
    mem_req_t   next_req;
    logic       next_done;
    logic       fin;
    addr_t      fin_addr;
    reg_code_t  dst_code;
    reg_code_t  src_code;

    // first cycle decodes the byte straight off the bus
    assign opcode_o = (state == S0) ? mem_data_i : opcode_q;
    assign dst_code = reg_code_t'(opcode_o[5:3]);
    assign src_code = reg_code_t'(opcode_o[2:0]);
    assign pc_inc   = mem_req_o.addr + addr_t'(1);

    always_comb begin
        next_state     = S0;
        next_nn_lo     = nn_lo;
        next_ret       = ret_addr;
        next_req.addr  = mem_req_o.addr;
        next_req.rd    = 1'b0;
        next_req.wr    = 1'b0;
        next_req.wdata = '0;
        fin            = 1'b0;
        fin_addr       = pc_inc;
        reg_wr_en_o    = 1'b0;
        reg_wr_code_o  = dst_code;
        reg_wr_data_o  = mem_data_i;
        reg_rd_code_o  = src_code;
        pair_sel_o     = opcode_o[4] ? DE : BC;

        case (group_i)
            LD_REG_REG: begin
                reg_wr_en_o   = 1'b1;
                reg_wr_data_o = reg_rd_data_i;
                fin           = 1'b1;
            end
            LD_REG_IMMED: begin
                if (state == S0) begin
                    next_req.addr = pc_inc;    // fetch n
                    next_req.rd   = 1'b1;
                    next_state    = S1;
                end else begin
                    reg_wr_en_o = 1'b1;
                    fin         = 1'b1;
                end
            end
            LD_A_BCDE: begin
                if (state == S0) begin
                    next_ret      = pc_inc;
                    next_req.addr = pair_data_i;
                    next_req.rd   = 1'b1;
                    next_state    = S1;
                end else begin
                    reg_wr_en_o   = 1'b1;
                    reg_wr_code_o = A;
                    fin           = 1'b1;
                    fin_addr      = ret_addr;
                end
            end
            LD_BCDE_A, LD_HL_REG: begin
                if (state == S0) begin
                    if (group_i == LD_BCDE_A) begin
                        reg_rd_code_o = A;
                    end else begin
                        pair_sel_o = HL;
                    end
                    next_ret       = pc_inc;
                    next_req.addr  = pair_data_i;
                    next_req.wr    = 1'b1;
                    next_req.wdata = reg_rd_data_i;
                    next_state     = S1;
                end else begin
                    fin      = 1'b1;
                    fin_addr = ret_addr;
                end
            end
            LD_HL_IMMED: begin
                case (state)
                    S0: begin
                        next_req.addr = pc_inc;
                        next_req.rd   = 1'b1;
                        next_state    = S1;
                    end
                    S1: begin
                        pair_sel_o     = HL;
                        next_ret       = pc_inc;
                        next_req.addr  = pair_data_i;
                        next_req.wr    = 1'b1;
                        next_req.wdata = mem_data_i;
                        next_state     = S2;
                    end
                    default: begin
                        fin      = 1'b1;
                        fin_addr = ret_addr;
                    end
                endcase
            end
            LD_A_EXTADDR, LD_EXTADDR_A: begin
                case (state)
                    S0: begin
                        next_req.addr = pc_inc;
                        next_req.rd   = 1'b1;
                        next_state    = S1;
                    end
                    S1: begin
                        next_nn_lo    = mem_data_i;
                        next_req.addr = pc_inc;
                        next_req.rd   = 1'b1;
                        next_state    = S2;
                    end
                    S2: begin
                        next_ret      = pc_inc;
                        next_req.addr = {mem_data_i, nn_lo};
                        reg_rd_code_o = A;
                        if (group_i == LD_A_EXTADDR) begin
                            next_req.rd = 1'b1;
                        end else begin
                            next_req.wr    = 1'b1;
                            next_req.wdata = reg_rd_data_i;
                        end
                        next_state = S3;
                    end
                    default: begin
                        reg_wr_en_o   = (group_i == LD_A_EXTADDR);
                        reg_wr_code_o = A;
                        fin           = 1'b1;
                        fin_addr      = ret_addr;
                    end
                endcase
            end
            default: fin = 1'b1;    // one-byte no-op
        endcase

        next_done = fin;
        if (fin) begin
            next_req.addr = fin_addr;    // next opcode fetch
            next_req.rd   = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= S0;
            done_o    <= 1'b1;
            mem_req_o <= '{addr: `Z80_RESET_PC, rd: 1'b1, wr: 1'b0, wdata: '0};
        end else begin
            state     <= next_state;
            done_o    <= next_done;
            mem_req_o <= next_req;
        end
    end

    always_ff @(posedge clk) begin
        if (state == S0) begin
            opcode_q <= mem_data_i;
        end
        nn_lo    <= next_nn_lo;
        ret_addr <= next_ret;
    end

endmodule

// File: source/z80_load_core.sv
`timescale 1ns/1ns

module z80_load_core import z80_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  data_t    mem_data_i,
    output mem_req_t mem_req_o,
    output logic     done_o
);

    insn_group_t group;
    data_t       opcode;
    logic        reg_wr_en;
    reg_code_t   reg_wr_code;
    data_t       reg_wr_data;
    reg_code_t   reg_rd_code;
    data_t       reg_rd_data;
    pair_sel_t   pair_sel;
    addr_t       pair_data;

    load_sequencer u_seq (
        .clk           (clk),
        .reset         (reset),
        .mem_data_i    (mem_data_i),
        .mem_req_o     (mem_req_o),
        .done_o        (done_o),
        .group_i       (group),
        .opcode_o      (opcode),
        .reg_wr_en_o   (reg_wr_en),
        .reg_wr_code_o (reg_wr_code),
        .reg_wr_data_o (reg_wr_data),
        .reg_rd_code_o (reg_rd_code),
        .reg_rd_data_i (reg_rd_data),
        .pair_sel_o    (pair_sel),
        .pair_data_i   (pair_data)
    );

    instr_decoder u_dec (
        .opcode_i (opcode),
        .group_o  (group)
    );

    register_file u_regs (
        .clk         (clk),
        .reset       (reset),
        .wr_en_i     (reg_wr_en),
        .wr_code_i   (reg_wr_code),
        .wr_data_i   (reg_wr_data),
        .rd_code_i   (reg_rd_code),
        .rd_data_o   (reg_rd_data),
        .pair_sel_i  (pair_sel),
        .pair_data_o (pair_data)
    );

endmodule

// File: sim/load_tests.svh
task automatic expect_reset_bus(input string phase);
    check_eq(32'(mem_req.addr), 32'h0, {phase, ": fetch address"});
    check_eq(32'(mem_req.rd), 32'd1, {phase, ": rd"});
    check_eq(32'(mem_req.wr), 32'd0, {phase, ": wr"});
    check_eq(32'(done), 32'd1, {phase, ": done"});
endtask

task automatic reset_outputs();
    begin_reset();
    load_program(256'h0, 0);
    #1;
    expect_reset_bus("in reset");
    finish_reset();
    #1;
    expect_reset_bus("first cycle after reset");
endtask

task automatic store_from_register();
    begin_reset();
    load_program(256'h2600_2E80_065A_70, 7);    // LD H,0; LD L,80h; LD B,5Ah; LD (HL),B
    finish_reset();
    run_program(4);
    check_eq(32'(mem[8'h80]), 32'h5A, "LD (HL),B result");
endtask

task automatic register_moves();
    begin_reset();
    // LD C,C3h; LD D,C; HALT taken as no-op; LD E,D; LD L,90h; LD (HL),E
    load_program(256'h0EC3_51_76_5A_2E90_73, 8);
    finish_reset();
    run_program(6);
    check_eq(32'(mem[8'h90]), 32'hC3, "byte moved through C, D and E");
    check_eq(insn_len[2], 32'd1, "no-op length");
endtask

task automatic pair_addressed_loads();
    begin_reset();
    load_program(256'h0EA0_1EB0_0A_12, 6);    // LD C,A0h; LD E,B0h; LD A,(BC); LD (DE),A
    set_data_byte(8'hA0, 8'h69);
    finish_reset();
    run_program(4);
    check_eq(32'(mem[8'hB0]), 32'h69, "LD (DE),A copy");
    check_eq(32'(mem[8'hA0]), 32'h69, "source byte kept");
endtask

task automatic extended_loads();
    begin_reset();
    // LD A,(00D0h); LD (00D8h),A; LD L,C8h; LD (HL),7Eh
    load_program(256'h3AD000_32D800_2EC8_367E, 10);
    set_data_byte(8'hD0, 8'hE1);
    finish_reset();
    run_program(4);
    check_eq(32'(mem[8'hD8]), 32'hE1, "LD (nn),A copy");
    check_eq(32'(mem[8'hC8]), 32'h7E, "LD (HL),n store");
endtask

// one instruction from each kept group plus a no-op
task automatic cycle_timing();
    int expect_len [11] = '{2, 2, 2, 1, 1, 3, 2, 2, 4, 4, 2};
    begin_reset();
    load_program(256'h0E91_2E92_0A_57_00_36A5_2E93_72_329400_3A9200_02, 19);
    set_data_byte(8'h91, 8'h3C);
    finish_reset();
    run_program(11);
    for (int i = 0; i < 11; i++) begin
        check_eq(insn_len[i], expect_len[i], $sformatf("cycles of instruction %0d", i));
    end
    check_eq(32'(mem[8'h91]), 32'hA5, "LD (BC),A store");
    check_eq(32'(mem[8'h92]), 32'hA5, "LD (HL),n store");
    check_eq(32'(mem[8'h93]), 32'h3C, "LD (HL),D store");
    check_eq(32'(mem[8'h94]), 32'h3C, "LD (nn),A store");
endtask

// File: sim/tb_z80_load.sv
`timescale 1ns/1ns

module tb_z80_load import z80_pkg::*; ();

    localparam int CYCLE_LIMIT = 600;    // six tests need about 150 cycles with resets

    logic     clk;
    logic     reset;
    logic     load_image;
    data_t    mem_data;
    mem_req_t mem_req;
    logic     done;
    data_t    mem [256];
    data_t    image [256];       // program image copied into mem during reset
    int       insn_len [16];    // cycles per finished instruction
    int       cycle_count;
    int       check_count;
    int       error_count;

    z80_load_core DUT (
        .clk        (clk),
        .reset      (reset),
        .mem_data_i (mem_data),
        .mem_req_o  (mem_req),
        .done_o     (done)
    );

    assign mem_data = mem[mem_req.addr[7:0]];    // asynchronous read

    always @(posedge clk) begin
        if (load_image) begin
            for (int i = 0; i < 256; i++) begin
                mem[i] <= image[i];
            end
        end else if (mem_req.wr) begin
            mem[mem_req.addr[7:0]] <= mem_req.wdata;
        end
    end

    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string msg);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %0t ns: %s: got 0x%0h, expected 0x%0h",
                     $time, msg, actual, expected);
        end
    endtask

    task automatic begin_reset();
        @(negedge clk);
        reset = 1'b1;
    endtask

    // image goes into memory on the first reset cycle
    task automatic finish_reset();
        load_image = 1'b1;
        @(negedge clk);
        load_image = 1'b0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
    endtask

    // first address leftmost within the low count bytes of the vector
    task automatic load_program(input logic [255:0] bytes, input int count);
        for (int i = 0; i < 256; i++) begin
            image[i] = '0;
        end
        for (int i = 0; i < count; i++) begin
            image[i] = bytes[8*(count-1-i) +: 8];
        end
    endtask

    task automatic set_data_byte(input logic [7:0] addr, input data_t value);
        image[addr] = value;
    endtask

    // counts done pulses with the release cycle as cycle 0
    task automatic run_program(input int count);
        int cyc;
        int last;
        int seen;
        cyc = 0;
        last = 0;
        seen = 0;
        while (seen < count) begin
            @(negedge clk);
            cyc++;
            check_eq(32'(mem_req.rd & mem_req.wr), 32'd0, "rd and wr set together");
            if (done) begin
                insn_len[seen] = cyc - last;
                last = cyc;
                seen++;
            end
        end
    endtask

    `include "load_tests.svh"

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the core stopped finishing instructions",
                 CYCLE_LIMIT);
        $display("Test failures found");
        $finish;
    end

    initial begin
        reset = 1'b1;
        load_image = 1'b0;
        check_count = 0;
        error_count = 0;
        reset_outputs();
        store_from_register();
        register_moves();
        pair_addressed_loads();
        extended_loads();
        cycle_timing();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+source
+incdir+sim
source/z80_pkg.sv
source/register_file.sv
source/instr_decoder.sv
source/load_sequencer.sv
source/z80_load_core.sv
sim/tb_z80_load.sv

// File: run_sim.sh
#!/bin/sh
# verilator build and run of the z80 load core testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns -f verilog.f \
    --top-module tb_z80_load -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_z80_load > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Test failures found" sim.log; then
    exit 1
fi
exit 0
